/* hdl/mem_pkg.sv */
package mem_pkg;

	// --------------------------------------------------
	// bus widths
	// --------------------------------------------------
	localparam int ADDR_W       = 27;
	localparam int INT_ADDR_W   = 24;
	localparam int DATA_W       = 32;

	// --------------------------------------------------
	// memory banks
	// --------------------------------------------------
	localparam int NUM_BANKS    = 4;
	localparam int BANK_WORDS   = 256;
	localparam int BANK_SEL_LSB = 10;
	localparam int BANK_SEL_W   = $clog2(NUM_BANKS);
	localparam int WORD_IDX_W   = $clog2(BANK_WORDS);
	localparam int BURST_LEN    = 4;
	localparam int BEAT_W       = $clog2(BURST_LEN);
	localparam int BANK_LATENCY = 2;
	localparam int LAT_W        = $clog2(BANK_LATENCY + 1);

	// address map, memory below 64 MB
	localparam logic [ADDR_W-1:0] MEM_LIMIT    = 27'h400_0000;
	localparam logic [ADDR_W-1:0] RST_CFG_ADDR = MEM_LIMIT + 27'd0;

	// reset pulse stretcher
	localparam int RST_PULSE_CYCLES = 16;
	localparam int RST_CNT_W        = $clog2(RST_PULSE_CYCLES + 1);

	// --------------------------------------------------
	// enums
	// --------------------------------------------------
	typedef enum logic [1:0] {TGT_MEM, TGT_RST, TGT_PER} target_e;

	typedef enum logic {M_COMM, M_INT} master_e;

	typedef enum logic [1:0] {R_IDLE, R_ISSUE, R_WAIT} route_state_e;

	typedef enum logic [1:0] {B_IDLE, B_LAT, B_XFER, B_END} bank_state_e;

endpackage

/* hdl/mem_bank_if.sv */
`timescale 1ns/1ps

interface mem_bank_if
	import mem_pkg::*;
();

	// request side
	logic                   start;
	logic                   block;
	logic                   rw;
	logic                   clear;
	logic [WORD_IDX_W-1:0]  word_add;
	logic [DATA_W-1:0]      wdata;

	// response side
	logic [DATA_W-1:0]      rdata;
	logic                   valid;
	logic                   done;

	modport router (
		output start, block, rw, clear, word_add, wdata
	);

	modport bank (
		input  start, block, rw, clear, word_add, wdata,
		output rdata, valid, done
	);

	modport resp (
		input rdata, valid, done
	);

endinterface

/* hdl/request_router.sv */
`timescale 1ns/1ps

module request_router
	import mem_pkg::*;
(
	input  logic                    clock_i,
	input  logic                    rst_n_i,

	// comm master
	input  logic                    comm_req_i,
	input  logic                    comm_req_block_i,
	input  logic                    comm_rw_i,
	input  logic                    comm_clear_i,
	input  logic [ADDR_W-1:0]       comm_add_i,
	input  logic [DATA_W-1:0]       comm_data_i,

	// int master
	input  logic                    int_req_i,
	input  logic                    int_req_block_i,
	input  logic                    int_rw_i,
	input  logic                    int_clear_i,
	input  logic [INT_ADDR_W-1:0]   int_add_i,
	input  logic [DATA_W-1:0]       int_data_i,

	mem_bank_if.router              banks [NUM_BANKS],

	// peripheral bus
	output logic                    per_req_o,
	output logic                    per_rw_o,
	output logic [ADDR_W-1:0]       per_add_o,
	output logic [DATA_W-1:0]       per_data_o,

	// reset controller
	output logic                    rst_wr_o,
	output logic [1:0]              rst_cfg_o,

	// to the merger
	output master_e                 owner_o,
	output target_e                 target_o,
	output logic [BANK_SEL_W-1:0]   bank_sel_o,
	output logic                    busy_o,
	input  logic                    txn_done_i
);

	typedef struct packed {
		logic                rw;
		logic                block;
		logic [ADDR_W-1:0]   add;
		logic [DATA_W-1:0]   data;
	} req_t;

	route_state_e           state;
	master_e                owner_q;
	master_e                last_served;
	master_e                pend_owner;
	target_e                target_q;
	logic                   pend_valid;
	req_t                   cur_q;
	req_t                   pend_q;

	req_t                   comm_live, int_live;
	req_t                   comm_fld, int_fld;
	req_t                   win_fld, lose_fld;
	logic [ADDR_W-1:0]      int_byte_add;
	logic                   c_pend, i_pend;
	logic                   c_any, i_any;
	logic                   pick_int;
	logic                   own_clear;
	logic [DATA_W-1:0]      own_data;

	function automatic target_e decode(input logic [ADDR_W-1:0] add);
		if (add < MEM_LIMIT)
			return TGT_MEM;
		else if (add[ADDR_W-1:2] == RST_CFG_ADDR[ADDR_W-1:2])
			return TGT_RST;
		else
			return TGT_PER;
	endfunction

	// --------------------------------------------------
	// arbitration
	// --------------------------------------------------
	// int gives word addresses
	assign int_byte_add = {{(ADDR_W-INT_ADDR_W-2){1'b0}}, int_add_i, 2'b00};

	assign comm_live = '{rw: comm_rw_i, block: comm_req_block_i, add: comm_add_i,
		data: comm_data_i};
	assign int_live  = '{rw: int_rw_i, block: int_req_block_i, add: int_byte_add,
		data: int_data_i};

	assign c_pend   = pend_valid && (pend_owner == M_COMM);
	assign i_pend   = pend_valid && (pend_owner == M_INT);
	assign c_any    = comm_req_i || c_pend;
	assign i_any    = int_req_i || i_pend;
	// round robin, a held loser always wins next
	assign pick_int = i_any && (!c_any || (last_served == M_COMM));

	assign comm_fld = c_pend ? pend_q : comm_live;
	assign int_fld  = i_pend ? pend_q : int_live;
	assign win_fld  = pick_int ? int_fld : comm_fld;
	assign lose_fld = pick_int ? comm_live : int_live;

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state       <= R_IDLE;
			owner_q     <= M_COMM;
			last_served <= M_COMM;
			pend_owner  <= M_COMM;
			target_q    <= TGT_MEM;
			pend_valid  <= 1'b0;
		end else begin
			case (state)
				R_IDLE: begin
					if (c_any || i_any) begin
						owner_q     <= pick_int ? M_INT : M_COMM;
						last_served <= pick_int ? M_INT : M_COMM;
						pend_owner  <= pick_int ? M_COMM : M_INT;
						pend_valid  <= c_any && i_any;
						target_q    <= decode(win_fld.add);
						state       <= R_ISSUE;
					end
				end
				R_ISSUE: state <= R_WAIT;
				R_WAIT: begin
					if (txn_done_i) begin
						// back to memory so the next reset access shows as new
						target_q <= TGT_MEM;
						state    <= R_IDLE;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cur_q  <= '0;
			pend_q <= '0;
		end else if ((state == R_IDLE) && (c_any || i_any)) begin
			cur_q  <= win_fld;
			pend_q <= lose_fld;
		end
	end

	// --------------------------------------------------
	// issue
	// --------------------------------------------------
	assign own_clear = (owner_q == M_INT) ? int_clear_i : comm_clear_i;
	assign own_data  = (owner_q == M_INT) ? int_data_i : comm_data_i;

	assign bank_sel_o = cur_q.add[BANK_SEL_LSB +: BANK_SEL_W];

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank_drv
		assign banks[i].start    = (state == R_ISSUE) && (target_q == TGT_MEM) &&
			(bank_sel_o == BANK_SEL_W'(i));
		assign banks[i].block    = cur_q.block;
		assign banks[i].rw       = cur_q.rw;
		assign banks[i].word_add = cur_q.add[2 +: WORD_IDX_W];
		assign banks[i].clear    = (state == R_WAIT) && own_clear;
		// block write data follows the valid pulses
		assign banks[i].wdata    = cur_q.block ? own_data : cur_q.data;
	end

	assign per_req_o  = (state == R_ISSUE) && (target_q == TGT_PER);
	assign per_rw_o   = cur_q.rw;
	assign per_add_o  = cur_q.add;
	assign per_data_o = cur_q.data;

	assign rst_wr_o  = (state == R_ISSUE) && (target_q == TGT_RST) && cur_q.rw;
	assign rst_cfg_o = cur_q.data[1:0];

	assign owner_o  = owner_q;
	assign target_o = target_q;
	assign busy_o   = (state != R_IDLE);

endmodule

/* hdl/mem_bank.sv */
`timescale 1ns/1ps

module mem_bank
	import mem_pkg::*;
(
	input  logic        clock_i,
	input  logic        rst_n_i,
	mem_bank_if.bank    bus
);

	bank_state_e                state;
	logic [LAT_W-1:0]           lat_cnt;
	logic [BEAT_W-1:0]          beat;
	logic [WORD_IDX_W-1:0]      idx;
	logic                       clr_seen;
	logic                       last;
	logic [DATA_W-1:0]          mem [BANK_WORDS];

	// last word of this transfer
	assign last = !bus.block || (beat == BEAT_W'(BURST_LEN - 1)) || bus.clear || clr_seen;

	assign bus.valid = (state == B_XFER);
	assign bus.done  = (state == B_XFER) && last;
	assign bus.rdata = mem[idx];

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state    <= B_IDLE;
			lat_cnt  <= '0;
			beat     <= '0;
			idx      <= '0;
			clr_seen <= 1'b0;
		end else begin
			case (state)
				B_IDLE: begin
					if (bus.start) begin
						idx      <= bus.word_add;
						lat_cnt  <= '0;
						beat     <= '0;
						clr_seen <= 1'b0;
						state    <= B_LAT;
					end
				end
				B_LAT: begin
					// a clear before the first word still lets one word through
					clr_seen <= clr_seen | bus.clear;
					if (lat_cnt == LAT_W'(BANK_LATENCY - 1))
						state <= B_XFER;
					else
						lat_cnt <= lat_cnt + 1'b1;
				end
				B_XFER: begin
					// index wraps inside the bank
					idx  <= idx + 1'b1;
					beat <= beat + 1'b1;
					if (last)
						state <= B_END;
				end
				B_END: begin
					state <= B_IDLE;
				end
				default: state <= B_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// storage
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if ((state == B_XFER) && bus.rw)
			mem[idx] <= bus.wdata;
	end

endmodule

/* hdl/response_merge.sv */
`timescale 1ns/1ps

module response_merge
	import mem_pkg::*;
(
	input  logic                    clock_i,
	input  logic                    rst_n_i,
	mem_bank_if.resp                banks [NUM_BANKS],
	input  logic [DATA_W-1:0]       per_data_i,
	input  logic                    per_req_i,
	input  logic [1:0]              rst_cfg_i,
	input  master_e                 owner_i,
	input  target_e                 target_i,
	input  logic [BANK_SEL_W-1:0]   bank_sel_i,
	output logic                    comm_valid_o,
	output logic                    comm_done_o,
	output logic [DATA_W-1:0]       comm_data_o,
	output logic                    int_valid_o,
	output logic                    int_done_o,
	output logic [DATA_W-1:0]       int_data_o,
	output logic                    txn_done_o
);

	logic [NUM_BANKS-1:0]   b_valid;
	logic [NUM_BANKS-1:0]   b_done;
	logic [DATA_W-1:0]      b_rdata [NUM_BANKS];
	target_e                target_q;
	logic                   rst_req;
	logic                   side_wait;
	logic                   side_valid;
	logic [DATA_W-1:0]      side_data;
	logic                   sel_valid;
	logic                   sel_done;
	logic [DATA_W-1:0]      sel_data;
	logic                   to_int;

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank_rd
		assign b_valid[i] = banks[i].valid;
		assign b_done[i]  = banks[i].done;
		assign b_rdata[i] = banks[i].rdata;
	end

	// reset word access begins when target turns to it
	assign rst_req = (target_i == TGT_RST) && (target_q != TGT_RST);

	// --------------------------------------------------
	// peripheral and reset word path
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			target_q   <= TGT_MEM;
			side_wait  <= 1'b0;
			side_valid <= 1'b0;
		end else begin
			target_q   <= target_i;
			side_wait  <= per_req_i || rst_req;
			side_valid <= side_wait;
		end
	end

	// readback one cycle after the request
	always_ff @(posedge clock_i) begin
		if (side_wait)
			side_data <= (target_i == TGT_RST) ? {{(DATA_W-2){1'b0}}, rst_cfg_i} : per_data_i;
	end

	assign sel_valid = (target_i == TGT_MEM) ? b_valid[bank_sel_i] : side_valid;
	assign sel_done  = (target_i == TGT_MEM) ? b_done[bank_sel_i] : side_valid;
	assign sel_data  = (target_i == TGT_MEM) ? b_rdata[bank_sel_i] : side_data;

	// steer to the owner only
	assign to_int       = (owner_i == M_INT);
	assign comm_valid_o = sel_valid && !to_int;
	assign comm_done_o  = sel_done && !to_int;
	assign comm_data_o  = to_int ? '0 : sel_data;
	assign int_valid_o  = sel_valid && to_int;
	assign int_done_o   = sel_done && to_int;
	assign int_data_o   = to_int ? sel_data : '0;

	assign txn_done_o = sel_done;

endmodule

/* hdl/reset_controller.sv */
`timescale 1ns/1ps

module reset_controller
	import mem_pkg::*;
(
	input  logic        clock_i,
	input  logic        rst_n_i,
	input  logic        wr_i,
	input  logic [1:0]  cfg_i,
	output logic [1:0]  cfg_o,
	output logic [1:0]  reset_bus_o
);

	logic [1:0]             cfg_q;
	logic [1:0]             arm;
	logic [RST_CNT_W-1:0]   pulse_cnt;

	// --------------------------------------------------
	// configuration and pulse counter
	// --------------------------------------------------
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cfg_q     <= 2'b00;
			arm       <= 2'b00;
			pulse_cnt <= '0;
		end else begin
			if (wr_i)
				cfg_q <= cfg_i;

			// delay so the pulse starts just after the write completes
			arm <= {arm[0], wr_i};

			if (arm[1])
				pulse_cnt <= RST_CNT_W'(RST_PULSE_CYCLES);
			else if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - 1'b1;
		end
	end

	// selected lines high while counting
	assign reset_bus_o = (pulse_cnt != '0) ? cfg_q : 2'b00;

	assign cfg_o = cfg_q;

endmodule

/* hdl/mem_system_top.sv */
`timescale 1ns/1ps

module mem_system_top
	import mem_pkg::*;
(
	input  logic                    clock_i,
	input  logic                    rst_n_i,

	// comm master
	input  logic                    comm_req_i,
	input  logic                    comm_req_block_i,
	input  logic                    comm_rw_i,
	input  logic                    comm_clear_i,
	input  logic [ADDR_W-1:0]       comm_add_i,
	input  logic [DATA_W-1:0]       comm_data_i,
	output logic                    comm_ready_o,
	output logic                    comm_valid_o,
	output logic                    comm_done_o,
	output logic [DATA_W-1:0]       comm_data_o,

	// int master
	input  logic                    int_req_i,
	input  logic                    int_req_block_i,
	input  logic                    int_rw_i,
	input  logic                    int_clear_i,
	input  logic [INT_ADDR_W-1:0]   int_add_i,
	input  logic [DATA_W-1:0]       int_data_i,
	output logic                    int_ready_o,
	output logic                    int_valid_o,
	output logic                    int_done_o,
	output logic [DATA_W-1:0]       int_data_o,

	// peripheral bus
	output logic                    per_req_o,
	output logic                    per_rw_o,
	output logic [ADDR_W-1:0]       per_add_o,
	output logic [DATA_W-1:0]       per_data_o,
	input  logic [DATA_W-1:0]       per_data_i,

	output logic [1:0]              reset_bus_o
);

	master_e                owner;
	target_e                target;
	logic [BANK_SEL_W-1:0]  bank_sel;
	logic                   busy;
	logic                   txn_done;
	logic                   rst_wr;
	logic [1:0]             rst_cfg;
	logic [1:0]             rst_cfg_rd;

	mem_bank_if bank_bus [NUM_BANKS] ();

	assign comm_ready_o = ~busy;
	assign int_ready_o  = ~busy;

	// --------------------------------------------------
	// router
	// --------------------------------------------------
	request_router router_0 (
		.clock_i          (clock_i          ),
		.rst_n_i          (rst_n_i          ),
		.comm_req_i       (comm_req_i       ),
		.comm_req_block_i (comm_req_block_i ),
		.comm_rw_i        (comm_rw_i        ),
		.comm_clear_i     (comm_clear_i     ),
		.comm_add_i       (comm_add_i       ),
		.comm_data_i      (comm_data_i      ),
		.int_req_i        (int_req_i        ),
		.int_req_block_i  (int_req_block_i  ),
		.int_rw_i         (int_rw_i         ),
		.int_clear_i      (int_clear_i      ),
		.int_add_i        (int_add_i        ),
		.int_data_i       (int_data_i       ),
		.banks            (bank_bus         ),
		.per_req_o        (per_req_o        ),
		.per_rw_o         (per_rw_o         ),
		.per_add_o        (per_add_o        ),
		.per_data_o       (per_data_o       ),
		.rst_wr_o         (rst_wr           ),
		.rst_cfg_o        (rst_cfg          ),
		.owner_o          (owner            ),
		.target_o         (target           ),
		.bank_sel_o       (bank_sel         ),
		.busy_o           (busy             ),
		.txn_done_i       (txn_done         )
	);

	// --------------------------------------------------
	// memory banks
	// --------------------------------------------------
	generate
		for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
			mem_bank bank_i (
				.clock_i (clock_i     ),
				.rst_n_i (rst_n_i     ),
				.bus     (bank_bus[i] )
			);
		end
	endgenerate

	// --------------------------------------------------
	// responses and reset control
	// --------------------------------------------------
	response_merge merge_0 (
		.clock_i      (clock_i      ),
		.rst_n_i      (rst_n_i      ),
		.banks        (bank_bus     ),
		.per_data_i   (per_data_i   ),
		.per_req_i    (per_req_o    ),
		.rst_cfg_i    (rst_cfg_rd   ),
		.owner_i      (owner        ),
		.target_i     (target       ),
		.bank_sel_i   (bank_sel     ),
		.comm_valid_o (comm_valid_o ),
		.comm_done_o  (comm_done_o  ),
		.comm_data_o  (comm_data_o  ),
		.int_valid_o  (int_valid_o  ),
		.int_done_o   (int_done_o   ),
		.int_data_o   (int_data_o   ),
		.txn_done_o   (txn_done     )
	);

	reset_controller rst_cont_0 (
		.clock_i     (clock_i     ),
		.rst_n_i     (rst_n_i     ),
		.wr_i        (rst_wr      ),
		.cfg_i       (rst_cfg     ),
		.cfg_o       (rst_cfg_rd  ),
		.reset_bus_o (reset_bus_o )
	);

endmodule

/* bench/tb_mem_system.sv */
`timescale 1ns/1ps

module tb_mem_system
	import mem_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 6;

	logic                   clock_i;
	logic                   rst_n_i;
	logic                   comm_req_i, comm_req_block_i, comm_rw_i, comm_clear_i;
	logic [ADDR_W-1:0]      comm_add_i;
	logic [DATA_W-1:0]      comm_data_i;
	logic                   comm_ready_o, comm_valid_o, comm_done_o;
	logic [DATA_W-1:0]      comm_data_o;
	logic                   int_req_i, int_req_block_i, int_rw_i, int_clear_i;
	logic [INT_ADDR_W-1:0]  int_add_i;
	logic [DATA_W-1:0]      int_data_i;
	logic                   int_ready_o, int_valid_o, int_done_o;
	logic [DATA_W-1:0]      int_data_o;
	logic                   per_req_o, per_rw_o;
	logic [ADDR_W-1:0]      per_add_o;
	logic [DATA_W-1:0]      per_data_o;
	logic [DATA_W-1:0]      per_data_i;
	logic [1:0]             reset_bus_o;

	// reference memory keyed by byte address
	logic [DATA_W-1:0]      ref_mem [logic [ADDR_W-1:0]];
	logic [DATA_W-1:0]      wbuf [BURST_LEN];
	logic [DATA_W-1:0]      rbuf [BURST_LEN];
	int                     nvalid, first_lat, errors, err_mark, tests_run, tests_failed;
	int                     per_cnt = 0;
	int                     rb_high = 0;
	logic [1:0]             rb_val;
	logic                   per_rw_seen;
	logic [ADDR_W-1:0]      per_add_seen, a0, a1;
	logic [DATA_W-1:0]      per_data_seen;
	logic [1:0]             cfg;
	bit                     c_done, i_done, int_first;
	int                     cyc;
	int                     c_cnt, i_cnt;

	mem_system_top dut0 (.*);

	always #(CLK_PERIOD/2) clock_i = ~clock_i;

	// --------------------------------------------------
	// monitors and protocol assertions
	// --------------------------------------------------
	always @(negedge clock_i) begin
		if (per_req_o) begin
			per_cnt++;
			per_rw_seen   = per_rw_o;
			per_add_seen  = per_add_o;
			per_data_seen = per_data_o;
		end
		if (reset_bus_o != 2'b00) begin
			rb_high++;
			rb_val = reset_bus_o;
		end
	end

	a_excl: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		!(comm_valid_o && int_valid_o))
		else begin
			$display("%0t ns: valid on both masters at once", $time);
			errors++;
		end
	a_comm_done: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		comm_done_o |-> comm_valid_o)
		else begin
			$display("%0t ns: comm done without valid", $time);
			errors++;
		end
	a_int_done: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		int_done_o |-> int_valid_o)
		else begin
			$display("%0t ns: int done without valid", $time);
			errors++;
		end
	a_per_pulse: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		per_req_o |=> !per_req_o)
		else begin
			$display("%0t ns: per_req_o longer than one cycle", $time);
			errors++;
		end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic check_val(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		assert (act === exp) else begin
			$display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != err_mark)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "FAILED");
		err_mark = errors;
	endtask

	function automatic logic [ADDR_W-1:0] rand_mem_addr(input int bank);
		return ADDR_W'(bank << BANK_SEL_LSB) | ADDR_W'($urandom_range(0, BANK_WORDS-1) << 2);
	endfunction

	// word k of a block wraps inside its bank
	function automatic logic [ADDR_W-1:0] word_addr(input logic [ADDR_W-1:0] addr, input int k);
		logic [7:0] w;
		w = addr[9:2] + 8'(k);
		return {addr[ADDR_W-1:10], w, 2'b00};
	endfunction

	task automatic set_req(input bit on_int, input bit rw, input bit blk,
			input logic [ADDR_W-1:0] addr);
		if (on_int) begin
			int_req_i       = 1'b1;
			int_rw_i        = rw;
			int_req_block_i = blk;
			int_add_i       = addr[ADDR_W-2:2];
		end else begin
			comm_req_i       = 1'b1;
			comm_rw_i        = rw;
			comm_req_block_i = blk;
			comm_add_i       = addr;
		end
	endtask

	task automatic drop_req(input bit on_int);
		if (on_int)
			int_req_i = 1'b0;
		else
			comm_req_i = 1'b0;
	endtask

	task automatic set_data(input bit on_int, input logic [DATA_W-1:0] d);
		if (on_int)
			int_data_i = d;
		else
			comm_data_i = d;
	endtask

	task automatic set_clear(input bit on_int, input bit c);
		if (on_int)
			int_clear_i = c;
		else
			comm_clear_i = c;
	endtask

	// one transaction on one master, counted in cycles after req
	task automatic access(input bit on_int, input bit rw, input bit blk,
			input logic [ADDR_W-1:0] addr, input bit use_clear);
		int  n;
		bit  fin;
		bit  v;
		bit  d;
		logic [DATA_W-1:0] q;
		n = 0;
		@(negedge clock_i);
		while (!(on_int ? int_ready_o : comm_ready_o) && n < 50) begin
			@(negedge clock_i);
			n++;
		end
		check_true(on_int ? int_ready_o : comm_ready_o, "ready never returned high");
		set_req(on_int, rw, blk, addr);
		set_data(on_int, wbuf[0]);
		nvalid    = 0;
		first_lat = 0;
		n         = 0;
		fin       = 1'b0;
		while (!fin) begin
			@(negedge clock_i);
			n++;
			if (n == 1) begin
				drop_req(on_int);
				check_true(!comm_ready_o && !int_ready_o,
					"ready still high after an accepted request");
			end
			// clear during the latency phase
			if (use_clear && n == 2)
				set_clear(on_int, 1'b1);
			v = on_int ? int_valid_o : comm_valid_o;
			d = on_int ? int_done_o : comm_done_o;
			q = on_int ? int_data_o : comm_data_o;
			if (v) begin
				if (nvalid == 0)
					first_lat = n;
				if (nvalid < BURST_LEN)
					rbuf[nvalid] = q;
				if (rw && blk && nvalid < BURST_LEN)
					set_data(on_int, wbuf[nvalid]);
				nvalid++;
			end
			if (d) begin
				fin = 1'b1;
			end else if (n > 60) begin
				$display("%0t ns: no done from the DUT", $time);
				errors++;
				fin = 1'b1;
			end
		end
		set_clear(on_int, 1'b0);
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	initial begin
		void'($urandom(55));
		clock_i = 1'b0;
		rst_n_i = 1'b0;
		{comm_req_i, comm_req_block_i, comm_rw_i, comm_clear_i} = '0;
		{int_req_i, int_req_block_i, int_rw_i, int_clear_i} = '0;
		comm_add_i  = '0;
		comm_data_i = '0;
		int_add_i   = '0;
		int_data_i  = '0;
		per_data_i  = '0;
		{errors, err_mark, tests_run, tests_failed} = '0;
		repeat (10) @(posedge clock_i);
		@(negedge clock_i);
		rst_n_i = 1'b1;

		// single accesses, read back from the other master
		check_true(comm_ready_o && int_ready_o, "ready low after reset");
		check_true(!per_req_o && reset_bus_o == 2'b00, "outputs active after reset");
		check_true(!comm_valid_o && !int_valid_o && !comm_done_o && !int_done_o,
			"valid or done active after reset");
		for (int m = 0; m < 2; m++) begin
			for (int b = 0; b < NUM_BANKS; b++) begin
				a0 = rand_mem_addr(b);
				wbuf[0] = $urandom;
				access(m, 1'b1, 1'b0, a0, 1'b0);
				ref_mem[a0] = wbuf[0];
				check_val("write first valid latency", BANK_LATENCY + 2, first_lat);
				access(!m, 1'b0, 1'b0, a0, 1'b0);
				check_val("read first valid latency", BANK_LATENCY + 2, first_lat);
				check_val("valid count", 1, nvalid);
				check_val(m ? "comm_data_o" : "int_data_o", ref_mem[a0], rbuf[0]);
			end
		end
		end_test("single accesses");

		// blocks on each master
		for (int m = 0; m < 2; m++) begin
			a0 = rand_mem_addr($urandom_range(0, NUM_BANKS-1));
			for (int k = 0; k < BURST_LEN; k++)
				wbuf[k] = $urandom;
			access(m, 1'b1, 1'b1, a0, 1'b0);
			check_val("block write valid count", BURST_LEN, nvalid);
			for (int k = 0; k < BURST_LEN; k++)
				ref_mem[word_addr(a0, k)] = wbuf[k];
			access(m, 1'b0, 1'b1, a0, 1'b0);
			check_val("block read valid count", BURST_LEN, nvalid);
			for (int k = 0; k < BURST_LEN; k++)
				check_val(m ? "int_data_o" : "comm_data_o", ref_mem[word_addr(a0, k)], rbuf[k]);
		end
		end_test("block accesses");

		// clear cuts a block read short
		access(1'b0, 1'b0, 1'b1, a0, 1'b1);
		check_true(nvalid > 0 && nvalid < BURST_LEN, "clear did not shorten the block");
		@(negedge clock_i);
		check_val("comm_ready_o", 1, comm_ready_o);
		access(1'b0, 1'b0, 1'b0, a0, 1'b0);
		check_val("comm_data_o", ref_mem[a0], rbuf[0]);
		end_test("clear");

		// tie between both masters
		// comm is served last here so int wins the tie
		a0 = rand_mem_addr(0);
		a1 = rand_mem_addr(3);
		wbuf[0] = $urandom;
		access(1'b1, 1'b1, 1'b0, a1, 1'b0);
		ref_mem[a1] = wbuf[0];
		wbuf[0] = $urandom;
		access(1'b0, 1'b1, 1'b0, a0, 1'b0);
		ref_mem[a0] = wbuf[0];
		@(negedge clock_i);
		set_req(1'b0, 1'b0, 1'b0, a0);
		set_req(1'b1, 1'b0, 1'b0, a1);
		{c_done, i_done, int_first} = '0;
		c_cnt = 0;
		i_cnt = 0;
		cyc = 0;
		while (!(c_done && i_done) && cyc < 100) begin
			@(negedge clock_i);
			cyc++;
			if (cyc == 1) begin
				drop_req(1'b0);
				drop_req(1'b1);
			end
			if (int_valid_o) begin
				i_cnt++;
				check_val("int_data_o", ref_mem[a1], int_data_o);
			end
			if (comm_valid_o) begin
				c_cnt++;
				check_val("comm_data_o", ref_mem[a0], comm_data_o);
			end
			if (int_done_o) begin
				i_done    = 1'b1;
				int_first = !c_done;
			end
			if (comm_done_o)
				c_done = 1'b1;
		end
		check_true(c_done && i_done, "a tied request never completed");
		check_true(int_first, "int was not served first on the tie");
		check_val("int_valid_o count", 1, i_cnt);
		check_val("comm_valid_o count", 1, c_cnt);
		end_test("arbitration");

		// peripheral write and read
		a0 = MEM_LIMIT + ADDR_W'($urandom_range(1, 1023) << 2);
		wbuf[0] = $urandom;
		cyc = per_cnt;
		access(1'b0, 1'b1, 1'b0, a0, 1'b0);
		check_val("per_req_o pulses", 1, per_cnt - cyc);
		check_val("per_rw_o", 1, per_rw_seen);
		check_val("per_add_o", a0, per_add_seen);
		check_val("per_data_o", wbuf[0], per_data_seen);
		check_val("peripheral latency", 3, first_lat);
		per_data_i = $urandom;
		access(1'b0, 1'b0, 1'b0, a0, 1'b0);
		check_val("per_rw_o", 0, per_rw_seen);
		check_val("comm_data_o", per_data_i, rbuf[0]);
		check_val("peripheral latency", 3, first_lat);
		end_test("peripheral");

		// reset configuration word
		cfg = 2'($urandom_range(1, 3));
		wbuf[0] = {30'($urandom), cfg};
		rb_high = 0;
		access(1'b0, 1'b1, 1'b0, RST_CFG_ADDR, 1'b0);
		check_val("reset word latency", 3, first_lat);
		repeat (RST_PULSE_CYCLES + 4) @(negedge clock_i);
		check_val("reset_bus_o high cycles", RST_PULSE_CYCLES, rb_high);
		check_val("reset_bus_o", cfg, rb_val);
		access(1'b0, 1'b0, 1'b0, RST_CFG_ADDR, 1'b0);
		check_val("comm_data_o", {30'd0, cfg}, rbuf[0]);
		end_test("reset controller");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog
	initial begin
		#((NUM_TESTS * 200 + 20) * CLK_PERIOD);
		$display("timeout, the tests did not finish in time");
		$display("Finished with errors");
		$finish;
	end

endmodule

/* project.f */
hdl/mem_pkg.sv
hdl/mem_bank_if.sv
hdl/request_router.sv
hdl/mem_bank.sv
hdl/response_merge.sv
hdl/reset_controller.sv
hdl/mem_system_top.sv
bench/tb_mem_system.sv
